//--- src/nand_cmd_pkg.sv
package nand_cmd_pkg;

  ////////////////////
  // host and flash words
  ////////////////////

  typedef logic [15:0] cmd_word_t;
  typedef logic [7:0]  flash_cmd_t;

  // single flash command bytes
  localparam flash_cmd_t CMD_READ0   = 8'h00;
  localparam flash_cmd_t CMD_READ1   = 8'h30;
  localparam flash_cmd_t CMD_ERASE0  = 8'h60;
  localparam flash_cmd_t CMD_ERASE1  = 8'hD0;
  localparam flash_cmd_t CMD_STATUS  = 8'h70;
  localparam flash_cmd_t CMD_PROG0   = 8'h80;
  localparam flash_cmd_t CMD_PROG1   = 8'h10;
  localparam flash_cmd_t CMD_READ_ID = 8'h90;
  localparam flash_cmd_t CMD_RESET   = 8'hFF;

  // host command words, two bytes each
  localparam cmd_word_t WORD_PROGRAM = {CMD_PROG0, CMD_PROG1};
  localparam cmd_word_t WORD_STATUS  = {CMD_STATUS, 8'h00};
  localparam cmd_word_t WORD_ERASE   = {CMD_ERASE0, CMD_ERASE1};
  localparam cmd_word_t WORD_READ    = {CMD_READ0, CMD_READ1};
  localparam cmd_word_t WORD_RESET   = {CMD_RESET, 8'h00};
  // read id matches on the upper byte only
  localparam cmd_word_t ID_PREFIX    = {CMD_READ_ID, 8'h00};

  typedef enum logic [2:0] {
    OP_NONE,
    OP_RESET,
    OP_STATUS,
    OP_READ_ID,
    OP_ERASE,
    OP_PROGRAM,
    OP_READ
  } op_t;

  // one entry per kind of bus activity
  typedef enum logic [3:0] {
    STEP_IDLE,
    STEP_LATCH,
    STEP_CMD,
    STEP_ADDR,
    STEP_ID_ADDR,
    STEP_REG,
    STEP_WRITE_PAGE,
    STEP_READ_PAGE,
    STEP_DRAIN,
    STEP_DONE
  } step_t;

endpackage

//--- src/nand_ctrl_pkg.sv
package nand_ctrl_pkg;

  ////////////////////
  // sequencer states
  ////////////////////

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_DECODE,
    // command byte onto the bus, then its toggle
    ST_CMD_LATCH,
    ST_CMD_TOG,
    // 00 address cycle of read id
    ST_ID_LATCH,
    ST_ID_TOG,
    ST_ADDR,
    // fixed delay, then ready/busy
    ST_TIMER,
    ST_READY,
    ST_REG,
    ST_WRITE,
    ST_READ,
    ST_DRAIN,
    ST_DONE
  } state_t;

  ////////////////////
  // bus side vectors
  ////////////////////

  // timing controller code
  typedef logic [2:0]  toggle_code_t;
  // 00 data, 10 address, 11 command
  typedef logic [1:0]  cad_sel_t;
  // col1, col2, row1, row2, row3
  typedef logic [2:0]  amux_sel_t;
  typedef logic [11:0] reg_addr_t;
  typedef logic [31:0] fifo_cnt_t;
  typedef logic [11:0] field_len_t;

  ////////////////////
  // wait timer, in clk cycles
  ////////////////////

  localparam int unsigned T_CLR_CYCLES = 3;
  // busy delay after erase confirm
  localparam int unsigned T_WB_CYCLES  = 6;

  ////////////////////
  // buffer registers
  ////////////////////

  // six id bytes from here upward
  localparam reg_addr_t ID_REG_BASE = 12'h800;
  localparam reg_addr_t STATUS_REG  = 12'h806;

endpackage

//--- src/nand_step_if.sv
`timescale 1ns/1ns

interface nand_step_if;
  import nand_cmd_pkg::*;
  import nand_ctrl_pkg::*;

  step_t      step;
  // valid with STEP_LATCH
  flash_cmd_t cmd_byte;
  // valid with STEP_ADDR
  amux_sel_t  addr_idx;
  // valid with STEP_REG where all ones selects status
  logic [2:0] reg_idx;
  logic       latch_row;
  logic       latch_col;
  logic       chip_hold;
  // toggle finished and seen by the sequencer in the same cycle
  logic       tog_done;

  modport seq (
    output step, cmd_byte, addr_idx, reg_idx,
    output latch_row, latch_col, chip_hold,
    input  tog_done
  );

  modport drv (
    input  step, cmd_byte, addr_idx, reg_idx,
    input  latch_row, latch_col, chip_hold,
    output tog_done
  );

endinterface

//--- src/nand_cmd_decoder.sv
`timescale 1ns/1ns

module nand_cmd_decoder (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   start_i,
  input  nand_cmd_pkg::cmd_word_t command_i,
  output nand_cmd_pkg::op_t      op_o,
  output logic                   id_long_o
);
  import nand_cmd_pkg::*;

  op_t op_d;

  // classify the raw command word
  always_comb begin
    op_d = OP_NONE;
    if (command_i[15:8] == ID_PREFIX[15:8]) begin
      op_d = OP_READ_ID;
    end else begin
      case (command_i)
        WORD_RESET:   op_d = OP_RESET;
        WORD_STATUS:  op_d = OP_STATUS;
        WORD_ERASE:   op_d = OP_ERASE;
        WORD_PROGRAM: op_d = OP_PROGRAM;
        WORD_READ:    op_d = OP_READ;
        default:      op_d = OP_NONE;
      endcase
    end
  end

  // captured on start only
  always_ff @(posedge clk) begin
    if (!rstn) begin
      op_o      <= OP_NONE;
      id_long_o <= 1'b0;
    end else if (start_i) begin
      op_o      <= op_d;
      // bit 5 asks for the 6 byte id
      id_long_o <= command_i[5];
    end
  end

endmodule

//--- src/nand_sequencer.sv
`timescale 1ns/1ns

module nand_sequencer (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     start_i,
  input  nand_cmd_pkg::op_t        op_i,
  input  logic                     id_long_i,
  input  logic                     r_nb_i,
  input  logic                     address_num_i,
  input  logic                     page_width_i,
  input  logic                     interface_i,
  input  nand_ctrl_pkg::fifo_cnt_t  fifo_rdata_cnt_i,
  input  nand_ctrl_pkg::field_len_t data_field_i,
  nand_step_if.seq                 step,
  output logic                     acnt_rst_o,
  output nand_ctrl_pkg::state_t    state_o
);
  import nand_cmd_pkg::*;
  import nand_ctrl_pkg::*;

  state_t     state;
  op_t        op_r;
  logic       id_long_r;
  flash_cmd_t cmd_r;
  amux_sel_t  addr_r;
  amux_sel_t  next_addr;
  logic       last_addr;
  logic [2:0] reg_idx_r;
  logic       last_reg;
  logic [3:0] wait_cnt;
  logic [3:0] wait_lim;
  logic       timer_done;
  logic       prog_setup;
  logic       fifo_full;

  ////////////////////
  // wait timer
  ////////////////////

  // restarts on every entry to ST_TIMER
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wait_cnt <= '0;
    end else if (state == ST_TIMER) begin
      wait_cnt <= wait_cnt + 4'd1;
    end else begin
      wait_cnt <= '0;
    end
  end

  // erase confirm needs the longer tWB
  assign wait_lim   = (cmd_r == CMD_ERASE1) ? 4'(T_WB_CYCLES - 1) : 4'(T_CLR_CYCLES - 1);
  assign timer_done = (state == ST_TIMER) && (wait_cnt == wait_lim);

  ////////////////////
  // sequence helpers
  ////////////////////

  // col2 only with wide pages, row3 only with 3 row bytes
  assign next_addr = (addr_r == 3'd0 && !page_width_i) ? 3'd2 : addr_r + 3'd1;
  assign last_addr = (addr_r == 3'd4) ||
                     (addr_r == 3'd3 && !address_num_i && op_r != OP_ERASE);

  assign last_reg  = (op_r != OP_READ_ID) || (reg_idx_r == 3'd5) ||
                     (reg_idx_r == 3'd3 && !id_long_r);

  // page read is complete one word past the data field
  assign fifo_full = (fifo_rdata_cnt_i == fifo_cnt_t'(data_field_i) + 32'd1);

  // address setup wait of page program
  assign prog_setup = (state == ST_TIMER) && (cmd_r == CMD_PROG0);

  ////////////////////
  // operation FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= ST_IDLE;
      op_r      <= OP_NONE;
      id_long_r <= 1'b0;
      cmd_r     <= '0;
      addr_r    <= '0;
      reg_idx_r <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start_i) begin
            state <= ST_DECODE;
          end
        end
        ST_DECODE: begin
          op_r      <= op_i;
          id_long_r <= id_long_i;
          state     <= ST_CMD_LATCH;
          case (op_i)
            OP_RESET:   cmd_r <= CMD_RESET;
            OP_STATUS:  cmd_r <= CMD_STATUS;
            OP_READ_ID: cmd_r <= CMD_READ_ID;
            OP_ERASE:   cmd_r <= CMD_ERASE0;
            OP_PROGRAM: cmd_r <= CMD_PROG0;
            OP_READ:    cmd_r <= CMD_READ0;
            default:    state <= ST_IDLE;
          endcase
        end
        ST_CMD_LATCH: begin
          state <= ST_CMD_TOG;
        end
        ST_CMD_TOG: begin
          if (step.tog_done) begin
            case (cmd_r)
              CMD_READ_ID: begin
                cmd_r <= CMD_READ0;
                state <= ST_ID_LATCH;
              end
              // erase has row bytes only
              CMD_ERASE0: begin
                addr_r <= 3'd2;
                state  <= ST_ADDR;
              end
              CMD_PROG0, CMD_READ0: begin
                addr_r <= 3'd0;
                state  <= ST_ADDR;
              end
              default: state <= ST_TIMER;
            endcase
          end
        end
        ST_ID_LATCH: begin
          state <= ST_ID_TOG;
        end
        ST_ID_TOG: begin
          if (step.tog_done) begin
            reg_idx_r <= 3'd0;
            state     <= ST_REG;
          end
        end
        ST_ADDR: begin
          if (step.tog_done) begin
            if (!last_addr) begin
              addr_r <= next_addr;
            end else if (op_r == OP_ERASE) begin
              cmd_r <= CMD_ERASE1;
              state <= ST_CMD_LATCH;
            end else if (op_r == OP_READ && interface_i) begin
              cmd_r <= CMD_READ1;
              state <= ST_CMD_LATCH;
            end else begin
              state <= ST_TIMER;
            end
          end
        end
        ST_TIMER: begin
          if (timer_done) begin
            state <= ST_READY;
          end
        end
        ST_READY: begin
          if (r_nb_i) begin
            case (cmd_r)
              CMD_STATUS: begin
                reg_idx_r <= '1;
                state     <= ST_REG;
              end
              // erase and program finish with a status read
              CMD_ERASE1, CMD_PROG1: begin
                cmd_r <= CMD_STATUS;
                state <= ST_CMD_LATCH;
              end
              CMD_PROG0:            state <= ST_WRITE;
              CMD_READ0, CMD_READ1: state <= ST_READ;
              default:              state <= ST_DONE;
            endcase
          end
        end
        ST_REG: begin
          if (step.tog_done) begin
            if (last_reg) begin
              state <= ST_DONE;
            end else begin
              reg_idx_r <= reg_idx_r + 3'd1;
            end
          end
        end
        ST_WRITE: begin
          if (step.tog_done) begin
            cmd_r <= CMD_PROG1;
            state <= ST_CMD_LATCH;
          end
        end
        ST_READ: begin
          if (step.tog_done) begin
            state <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          if (fifo_full) begin
            state <= ST_DONE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // step outputs
  ////////////////////

  always_comb begin
    step.step = STEP_IDLE;
    case (state)
      ST_CMD_LATCH, ST_ID_LATCH: step.step = STEP_LATCH;
      ST_CMD_TOG:                step.step = STEP_CMD;
      ST_ID_TOG:                 step.step = STEP_ID_ADDR;
      ST_ADDR:                   step.step = STEP_ADDR;
      ST_REG:                    step.step = STEP_REG;
      ST_WRITE:                  step.step = STEP_WRITE_PAGE;
      ST_READ:                   step.step = STEP_READ_PAGE;
      ST_DRAIN:                  step.step = STEP_DRAIN;
      ST_DONE:                   step.step = STEP_DONE;
      default:                   step.step = STEP_IDLE;
    endcase
  end

  assign step.cmd_byte = cmd_r;
  assign step.addr_idx = addr_r;
  assign step.reg_idx  = reg_idx_r;

  // address latches armed with the first command byte
  assign step.latch_row = (state == ST_CMD_LATCH) &&
                          (cmd_r == CMD_ERASE0 || cmd_r == CMD_PROG0 || cmd_r == CMD_READ0);
  assign step.latch_col = ((state == ST_CMD_LATCH) &&
                           (cmd_r == CMD_PROG0 || cmd_r == CMD_READ0)) ||
                          (prog_setup && timer_done);

  // chip stays selected from the read wait through the drain
  assign step.chip_hold = (op_r == OP_READ) &&
                          (state inside {ST_TIMER, ST_READY, ST_READ, ST_DRAIN});

  // data address counter restarts per operation and before program data
  assign acnt_rst_o = (state == ST_DECODE) || (prog_setup && wait_cnt == 4'd0);

  assign state_o = state;

endmodule

//--- src/nand_bus_driver.sv
`timescale 1ns/1ns

module nand_bus_driver (
  nand_step_if.drv                    step,
  input  logic                        toggle_done_i,
  output logic                        toggle_en_o,
  output nand_ctrl_pkg::toggle_code_t cmd_code_o,
  output nand_cmd_pkg::flash_cmd_t    cmd_o,
  output logic                        cmd_en_o,
  output nand_ctrl_pkg::cad_sel_t     cad_sel_o,
  output nand_ctrl_pkg::amux_sel_t    amux_sel_o,
  output nand_ctrl_pkg::reg_addr_t    bf_reg_addr_o,
  output logic                        radr_en_o,
  output logic                        cadr_en_o,
  output logic                        ce_n_o,
  output logic                        flash_read_o,
  output logic                        flash_write_o,
  output logic                        op_done_o
);
  import nand_cmd_pkg::*;
  import nand_ctrl_pkg::*;

  ////////////////////
  // step decode
  ////////////////////

  always_comb begin
    toggle_en_o   = 1'b0;
    cmd_code_o    = 3'b000;
    cmd_o         = '0;
    cmd_en_o      = 1'b0;
    // command bus by default
    cad_sel_o     = 2'b11;
    amux_sel_o    = 3'b000;
    bf_reg_addr_o = '0;
    flash_read_o  = 1'b0;
    flash_write_o = 1'b0;
    op_done_o     = 1'b0;
    case (step.step)
      STEP_LATCH: begin
        cmd_o    = step.cmd_byte;
        cmd_en_o = 1'b1;
      end
      STEP_CMD: begin
        toggle_en_o = 1'b1;
      end
      STEP_ADDR: begin
        toggle_en_o = 1'b1;
        cmd_code_o  = 3'b001;
        cad_sel_o   = 2'b10;
        amux_sel_o  = step.addr_idx;
      end
      // id address byte comes from the command register
      STEP_ID_ADDR: begin
        toggle_en_o = 1'b1;
        cmd_code_o  = 3'b001;
      end
      STEP_REG: begin
        toggle_en_o   = 1'b1;
        cmd_code_o    = 3'b010;
        bf_reg_addr_o = (step.reg_idx == '1) ? STATUS_REG :
                        ID_REG_BASE + reg_addr_t'(step.reg_idx);
      end
      // one full page from the host fifo
      STEP_WRITE_PAGE: begin
        toggle_en_o   = 1'b1;
        cmd_code_o    = 3'b111;
        cad_sel_o     = 2'b00;
        flash_write_o = 1'b1;
      end
      STEP_READ_PAGE: begin
        toggle_en_o  = 1'b1;
        cmd_code_o   = 3'b101;
        flash_read_o = 1'b1;
      end
      STEP_DRAIN: begin
        flash_read_o = 1'b1;
      end
      STEP_DONE: begin
        op_done_o = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign radr_en_o = step.latch_row;
  assign cadr_en_o = step.latch_col;
  assign ce_n_o    = !step.chip_hold;

  // done only counts while a toggle is requested
  assign step.tog_done = toggle_en_o && toggle_done_i;

endmodule

//--- src/nand_mfsm_top.sv
`timescale 1ns/1ns

module nand_mfsm_top (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        r_nb_i,
  input  logic                        start_i,
  input  nand_cmd_pkg::cmd_word_t     command_i,
  input  logic                        interface_i,
  input  logic                        address_num_i,
  input  logic                        page_width_i,
  input  nand_ctrl_pkg::fifo_cnt_t     fifo_rdata_cnt_i,
  input  nand_ctrl_pkg::field_len_t    data_field_i,
  output nand_ctrl_pkg::state_t       state_o,
  // timing controller
  input  logic                        toggle_done_i,
  output logic                        toggle_en_o,
  output logic                        acnt_rst_o,
  output nand_ctrl_pkg::toggle_code_t cmd_code_o,
  output nand_cmd_pkg::flash_cmd_t    cmd_o,
  output logic                        cmd_en_o,
  output logic                        radr_en_o,
  output logic                        cadr_en_o,
  output logic                        ce_n_o,
  // flash data path
  output nand_ctrl_pkg::reg_addr_t    bf_reg_addr_o,
  output nand_ctrl_pkg::cad_sel_t     cad_sel_o,
  output nand_ctrl_pkg::amux_sel_t    amux_sel_o,
  output logic                        op_done_o,
  output logic                        flash_read_o,
  output logic                        flash_write_o
);
  import nand_cmd_pkg::*;

  op_t  op;
  logic id_long;

  nand_step_if step_bus ();

  nand_cmd_decoder i_cmd_decoder (
    .clk       (clk),
    .rstn      (rstn),
    .start_i   (start_i),
    .command_i (command_i),
    .op_o      (op),
    .id_long_o (id_long)
  );

  nand_sequencer i_sequencer (
    .clk              (clk),
    .rstn             (rstn),
    .start_i          (start_i),
    .op_i             (op),
    .id_long_i        (id_long),
    .r_nb_i           (r_nb_i),
    .address_num_i    (address_num_i),
    .page_width_i     (page_width_i),
    .interface_i      (interface_i),
    .fifo_rdata_cnt_i (fifo_rdata_cnt_i),
    .data_field_i     (data_field_i),
    .step             (step_bus.seq),
    .acnt_rst_o       (acnt_rst_o),
    .state_o          (state_o)
  );

  nand_bus_driver i_bus_driver (
    .step          (step_bus.drv),
    .toggle_done_i (toggle_done_i),
    .toggle_en_o   (toggle_en_o),
    .cmd_code_o    (cmd_code_o),
    .cmd_o         (cmd_o),
    .cmd_en_o      (cmd_en_o),
    .cad_sel_o     (cad_sel_o),
    .amux_sel_o    (amux_sel_o),
    .bf_reg_addr_o (bf_reg_addr_o),
    .radr_en_o     (radr_en_o),
    .cadr_en_o     (cadr_en_o),
    .ce_n_o        (ce_n_o),
    .flash_read_o  (flash_read_o),
    .flash_write_o (flash_write_o),
    .op_done_o     (op_done_o)
  );

endmodule

//--- tb/tb_nand_mfsm.sv
`timescale 1ns/1ns

module tb_nand_mfsm;
  import nand_cmd_pkg::*;
  import nand_ctrl_pkg::*;

  localparam int NUM_CASES    = 16;
  localparam int CASE_WORDS   = 12;
  localparam int MAX_CYCLES   = NUM_CASES * 400;
  // watch window for commands that must stay silent
  localparam int QUIET_CYCLES = 20;

  logic       clk;
  logic       rstn;
  logic       start_i;
  cmd_word_t  command_i;
  logic       interface_i;
  logic       address_num_i;
  logic       page_width_i;
  field_len_t data_field_i;
  logic       r_nb_i = 1'b1;
  logic       toggle_done_i = 1'b0;
  fifo_cnt_t  fifo_rdata_cnt_i = '0;

  state_t       state_o;
  logic         toggle_en_o;
  logic         acnt_rst_o;
  toggle_code_t cmd_code_o;
  flash_cmd_t   cmd_o;
  logic         cmd_en_o;
  logic         radr_en_o;
  logic         cadr_en_o;
  logic         ce_n_o;
  reg_addr_t    bf_reg_addr_o;
  cad_sel_t     cad_sel_o;
  amux_sel_t    amux_sel_o;
  logic         op_done_o;
  logic         flash_read_o;
  logic         flash_write_o;

  logic [31:0] cases [0:NUM_CASES*CASE_WORDS-1];
  logic [31:0] lfsr = 32'hfe10_4c76;
  int          check_cnt = 0;
  int          err_cnt = 0;
  int          cycle_cnt = 0;

  // bus model state
  int tog_left = 0;
  int busy_left = 0;
  int rnd = 0;

  // trace of the running operation
  int          case_cyc = 0;
  int          first_cmd_cyc = 0;
  logic [31:0] cmd_trace = '0;
  int          cmd_bytes = 0;
  int          addr_togs = 0;
  logic [31:0] addr_trace = '0;
  int          reg_reads = 0;
  reg_addr_t   reg_seen [0:7];
  int          done_cnt = 0;
  logic        write_seen = 1'b0;
  logic        read_seen = 1'b0;
  fifo_cnt_t   fifo_at_done = '0;
  state_t      decode_state = ST_IDLE;
  logic        decode_acnt = 1'b0;

  nand_mfsm_top i_nand_mfsm_top (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  // galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // expected amux_sel_o order, one nibble per address cycle
  // col1 0, col2 1, row1 2, row2 3, row3 4
  function automatic logic [31:0] addr_order(input cmd_word_t cmd, input logic wide,
                                             input logic three_row);
    logic [31:0] seq;
    seq = '0;
    if (cmd == 16'h60D0) begin
      seq = 32'h234;
    end else if (cmd == 16'h8010 || cmd == 16'h0030) begin
      if (wide) begin
        seq = {seq[27:0], 4'h1};
      end
      seq = {seq[27:0], 4'h2};
      seq = {seq[27:0], 4'h3};
      if (three_row) begin
        seq = {seq[27:0], 4'h4};
      end
    end
    return seq;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // timing controller, flash and fifo models
  ////////////////////

  always @(posedge clk) begin
    #1;
    if (acnt_rst_o) begin
      fifo_rdata_cnt_i = '0;
    end else if (flash_read_o) begin
      fifo_rdata_cnt_i = fifo_rdata_cnt_i + 32'd1;
    end
    // done is a single cycle answer
    if (toggle_done_i) begin
      toggle_done_i = 1'b0;
    end else if (toggle_en_o) begin
      if (tog_left == 0) begin
        take_bits(2, rnd);
        tog_left = rnd + 1;
      end
      tog_left--;
      if (tog_left == 0) begin
        toggle_done_i = 1'b1;
        // flash goes busy after a command cycle
        if (cmd_code_o == 3'b000) begin
          take_bits(3, rnd);
          busy_left = rnd;
        end
      end
    end
    if (busy_left != 0) begin
      r_nb_i = 1'b0;
      busy_left--;
    end else begin
      r_nb_i = 1'b1;
    end
  end

  // trace capture mid cycle
  always @(negedge clk) begin
    if (start_i) begin
      case_cyc      = 0;
      first_cmd_cyc = 0;
      cmd_trace     = '0;
      cmd_bytes     = 0;
      addr_togs     = 0;
      addr_trace    = '0;
      reg_reads     = 0;
      done_cnt      = 0;
      write_seen    = 1'b0;
      read_seen     = 1'b0;
      fifo_at_done  = '0;
      decode_state  = ST_IDLE;
      decode_acnt   = 1'b0;
    end
    // second cycle of an operation is the decode state
    if (case_cyc == 1) begin
      decode_state = state_o;
      decode_acnt  = acnt_rst_o;
    end
    if (cmd_en_o) begin
      if (cmd_bytes == 0) begin
        first_cmd_cyc = case_cyc;
      end
      cmd_trace = {cmd_trace[23:0], cmd_o};
      cmd_bytes++;
    end
    if (toggle_en_o && toggle_done_i) begin
      if (cmd_code_o == 3'b001 && cad_sel_o == 2'b10) begin
        addr_togs++;
        addr_trace = {addr_trace[27:0], 1'b0, amux_sel_o};
      end
      if (cmd_code_o == 3'b010) begin
        if (reg_reads < 8) begin
          reg_seen[reg_reads[2:0]] = bf_reg_addr_o;
        end
        reg_reads++;
      end
    end
    write_seen = write_seen | flash_write_o;
    read_seen  = read_seen | flash_read_o;
    if (op_done_o) begin
      done_cnt++;
      fifo_at_done = fifo_rdata_cnt_i;
    end
    case_cyc++;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the operations did not finish within %0d cycles", MAX_CYCLES);
      $display("checks %0d, errors %0d", check_cnt, err_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////
  // stimulus and checks
  ////////////////////

  initial begin
    int    base;
    int    burst;
    string tag;
    rstn          = 1'b0;
    start_i       = 1'b0;
    command_i     = '0;
    interface_i   = 1'b0;
    address_num_i = 1'b0;
    page_width_i  = 1'b0;
    data_field_i  = '0;
    $readmemh("tb/nand_cases.txt", cases);
    repeat (8) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(posedge clk);
    #1;
    // enables low, chip deselected
    check_value("idle outputs",
                32'({toggle_en_o, cmd_en_o, op_done_o, flash_read_o, flash_write_o,
                     radr_en_o, cadr_en_o, acnt_rst_o, ce_n_o}),
                32'h001);

    for (int c = 0; c < NUM_CASES; c++) begin
      base          = c * CASE_WORDS;
      tag           = $sformatf("case %0d", c);
      burst         = int'(cases[base+11]);
      command_i     = cases[base][15:0];
      address_num_i = cases[base+1][0];
      page_width_i  = cases[base+2][0];
      interface_i   = cases[base+3][0];
      data_field_i  = cases[base+4][11:0];
      start_i       = 1'b1;
      @(posedge clk);
      #1;
      start_i = 1'b0;

      if (cases[base+10][0]) begin
        while (done_cnt == 0) begin
          @(posedge clk);
        end
        // a second done pulse would show up here
        repeat (2) @(posedge clk);
        #1;
      end else begin
        repeat (QUIET_CYCLES) @(posedge clk);
        #1;
      end

      check_value({tag, " cmd_o bytes"}, cmd_trace, cases[base+5]);
      check_value({tag, " cmd_en_o pulses"}, 32'(cmd_bytes), cases[base+6]);
      check_value({tag, " address toggles"}, 32'(addr_togs), cases[base+7]);
      check_value({tag, " amux_sel_o order"}, addr_trace,
                  addr_order(command_i, page_width_i, address_num_i));
      check_value({tag, " register reads"}, 32'(reg_reads), cases[base+8]);
      for (int r = 0; r < 8; r++) begin
        if (r < reg_reads && r < int'(cases[base+8])) begin
          check_value({tag, " bf_reg_addr_o"}, 32'(reg_seen[r]),
                      cases[base+9] + 32'(r));
        end
      end
      check_value({tag, " op_done_o pulses"}, 32'(done_cnt), cases[base+10]);
      check_value({tag, " state_o in decode cycle"}, 32'(decode_state), 32'(ST_DECODE));
      check_value({tag, " acnt_rst_o in decode cycle"}, 32'(decode_acnt), 32'd1);
      if (cmd_bytes != 0) begin
        check_value({tag, " first cmd_en_o cycle"}, 32'(first_cmd_cyc), 32'd2);
      end
      check_value({tag, " flash_write_o seen"}, 32'(write_seen), 32'(burst == 1));
      check_value({tag, " flash_read_o seen"}, 32'(read_seen), 32'(burst == 2));
      // read completes one word past the data field
      if (burst == 2) begin
        check_value({tag, " fifo_rdata_cnt_i at done"}, fifo_at_done,
                    32'(cases[base+4][11:0]) + 32'd1);
      end
      check_value({tag, " state_o at end"}, 32'(state_o), 32'(ST_IDLE));
    end

    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
src/nand_cmd_pkg.sv
src/nand_ctrl_pkg.sv
src/nand_step_if.sv
src/nand_cmd_decoder.sv
src/nand_sequencer.sv
src/nand_bus_driver.sv
src/nand_mfsm_top.sv
tb/tb_nand_mfsm.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the NAND main controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/1ns \
  -f project.f --top-module tb_nand_mfsm -Mdir "$OBJ" -o sim_nand
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/sim_nand" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  echo "simulation reported failure, see $LOG"
  exit 1
fi

exit 0

//--- tb/nand_cases.txt
// cmd  adr_num pg_wid intf field  bytes  n_bytes addr regs reg0 done burst
// burst: 0 none, 1 program data, 2 page read
FF00 0 0 0 010 000000FF 1 0 0 000 1 0
7000 0 0 0 010 00000070 1 0 1 806 1 0
9000 0 0 0 010 00009000 2 0 4 800 1 0
9020 0 0 0 010 00009000 2 0 6 800 1 0
60D0 0 0 0 010 0060D070 3 3 1 806 1 0
60D0 1 1 0 010 0060D070 3 3 1 806 1 0
8010 0 0 0 010 00801070 3 3 1 806 1 1
8010 0 1 0 010 00801070 3 4 1 806 1 1
8010 1 1 0 010 00801070 3 5 1 806 1 1
0030 0 0 0 020 00000000 1 3 0 000 1 2
0030 1 0 1 03F 00000030 2 4 0 000 1 2
0030 1 1 1 0FF 00000030 2 5 0 000 1 2
1234 0 0 0 010 00000000 0 0 0 000 0 0
7000 0 0 0 010 00000070 1 0 1 806 1 0
ABCD 1 1 1 010 00000000 0 0 0 000 0 0
9020 0 0 0 010 00009000 2 0 6 800 1 0
